/* verilog/sdp_brdma_cfg_pkg.sv */
/* bias read DMA layer configuration
   width typedefs, data-use enum and the layer config struct */

package sdp_brdma_cfg_pkg;

  //========================================
  // widths with a meaning
  //========================================
  typedef logic [12:0] dim_t;        // value minus one
  typedef logic [26:0] stride_t;     // in atoms
  typedef logic [26:0] atom_addr_t;  // atom granular address

  // which operand streams take the bias data
  typedef enum logic [1:0] {
    use_mul  = 2'd0,
    use_alu  = 2'd1,
    use_both = 2'd2
  } data_use_e;

  //========================================
  // layer configuration
  //========================================
  typedef struct packed {
    atom_addr_t base_addr;       // first atom of surface 0
    stride_t    line_stride;     // step between lines
    stride_t    surface_stride;  // step between surfaces
    dim_t       width;           // atoms per line, minus one
    dim_t       height;          // lines per surface, minus one
    dim_t       channel;         // surfaces, minus one
    data_use_e  data_use;
    logic       perf_dma_en;     // enables the stall counter
  } brdma_cfg_t;

endpackage

/* verilog/sdp_dma_pkg.sv */
/* memory read interface types
   atom and operand widths, read request and response payloads */

package sdp_dma_pkg;

  //========================================
  // data widths
  //========================================
  typedef logic [63:0] atom_t;      // one memory atom
  typedef logic [31:0] half_t;      // one operand word
  typedef logic [12:0] cq_entry_t;  // atoms per request, minus one

  //========================================
  // read request / response payloads
  //========================================
  typedef struct packed {
    sdp_brdma_cfg_pkg::atom_addr_t addr;  // start atom
    sdp_brdma_cfg_pkg::dim_t       size;  // atoms minus one
  } dma_rd_req_t;

  typedef struct packed {
    atom_t data;
  } dma_rd_rsp_t;

endpackage

/* verilog/sdp_brdma_fifo.sv */
/* synchronous valid/ready FIFO on a register array
   used for the context queue and the latency FIFO */

module sdp_brdma_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 13
) (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  input  logic             wr_valid,
  output logic             wr_ready,
  input  logic [WIDTH-1:0] wr_pd,
  output logic             rd_valid,
  input  logic             rd_ready,
  output logic [WIDTH-1:0] rd_pd
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];  // payload storage
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;        // entries held
  logic             push;
  logic             pop;

  assign wr_ready = (count != CW'(DEPTH));  // full drops ready
  assign rd_valid = (count != '0);
  assign rd_pd    = mem[rd_ptr];

  assign push = wr_valid & wr_ready;
  assign pop  = rd_valid & rd_ready;

  always_ff @(posedge nvdla_core_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_pd;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap at depth
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* verilog/sdp_brdma_ig.sv */
/* read request generator, one request per line of every surface
   also keeps the request stall counter */

module sdp_brdma_ig (
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  input  logic                             op_load,
  input  sdp_brdma_cfg_pkg::brdma_cfg_t    cfg,
  output logic                             req_valid,
  input  logic                             req_ready,
  output sdp_dma_pkg::dma_rd_req_t         req_pd,
  output logic                             cq_valid,
  input  logic                             cq_ready,
  output sdp_dma_pkg::cq_entry_t           cq_pd,
  output logic [31:0]                      stall_cnt
);

  typedef enum logic {
    idle,
    issue
  } ig_state_e;

  ig_state_e                     state;
  sdp_brdma_cfg_pkg::dim_t       line_cnt;   // line within surface
  sdp_brdma_cfg_pkg::dim_t       surf_cnt;   // surface index
  sdp_brdma_cfg_pkg::atom_addr_t line_addr;  // address of current line
  sdp_brdma_cfg_pkg::atom_addr_t surf_addr;  // start of current surface
  logic                          req_xfer;
  logic                          last_line;
  logic                          last_surf;

  //========================================
  // request and context entry go out together
  //========================================
  assign req_valid = (state == issue) & cq_ready;
  assign cq_valid  = (state == issue) & req_ready;
  assign req_xfer  = req_valid & req_ready;

  assign req_pd.addr = line_addr;
  assign req_pd.size = cfg.width;
  assign cq_pd       = sdp_dma_pkg::cq_entry_t'(cfg.width);  // atoms minus one

  assign last_line = (line_cnt == cfg.height);
  assign last_surf = (surf_cnt == cfg.channel);

  //========================================
  // surface-major address walk
  //========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state     <= idle;
      line_cnt  <= '0;
      surf_cnt  <= '0;
      line_addr <= '0;
      surf_addr <= '0;
    end else if (op_load) begin
      state     <= issue;
      line_cnt  <= '0;
      surf_cnt  <= '0;
      line_addr <= cfg.base_addr;
      surf_addr <= cfg.base_addr;
    end else if (req_xfer) begin
      if (!last_line) begin
        line_cnt  <= line_cnt + 1'b1;
        line_addr <= line_addr + cfg.line_stride;
      end else if (!last_surf) begin
        line_cnt  <= '0;
        surf_cnt  <= surf_cnt + 1'b1;
        surf_addr <= surf_addr + cfg.surface_stride;  // next surface start
        line_addr <= surf_addr + cfg.surface_stride;
      end else begin
        state <= idle;  // layer fully issued
      end
    end
  end

  // cycles a request waits on memory
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (op_load) begin
      stall_cnt <= '0;
    end else if (cfg.perf_dma_en && req_valid && !req_ready) begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

endmodule

/* verilog/sdp_brdma_eg.sv */
/* splits response atoms onto the ALU and MUL operand streams
   per context entry, and flags the end of the layer */

module sdp_brdma_eg (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          op_load,
  input  sdp_brdma_cfg_pkg::brdma_cfg_t cfg,
  input  logic                          cq_valid,
  output logic                          cq_ready,
  input  sdp_dma_pkg::cq_entry_t        cq_pd,
  input  logic                          lat_valid,
  output logic                          lat_ready,
  input  sdp_dma_pkg::dma_rd_rsp_t      lat_pd,
  output logic                          alu_valid,
  input  logic                          alu_ready,
  output sdp_dma_pkg::half_t            alu_pd,
  output logic                          mul_valid,
  input  logic                          mul_ready,
  output sdp_dma_pkg::half_t            mul_pd,
  output logic                          eg_done
);

  logic                   ctx_vld;     // context entry held
  sdp_dma_pkg::cq_entry_t ctx_size;    // atoms minus one
  sdp_dma_pkg::cq_entry_t atom_cnt;
  logic [26:0]            entry_total; // requests in the layer
  logic [26:0]            entry_cnt;   // entries finished
  logic                   alu_sent;
  logic                   mul_sent;
  logic                   is_both;
  logic                   alu_en;
  logic                   mul_en;
  logic                   active;
  logic                   alu_xfer;
  logic                   mul_xfer;
  logic                   atom_pop;
  logic                   last_atom;
  sdp_dma_pkg::half_t     atom_lo;
  sdp_dma_pkg::half_t     atom_hi;

  assign is_both = (cfg.data_use == sdp_brdma_cfg_pkg::use_both);
  assign alu_en  = is_both | (cfg.data_use == sdp_brdma_cfg_pkg::use_alu);
  assign mul_en  = is_both | (cfg.data_use == sdp_brdma_cfg_pkg::use_mul);
  assign active  = ctx_vld & lat_valid;
  assign atom_lo = lat_pd.data[31:0];
  assign atom_hi = lat_pd.data[63:32];

  //========================================
  // operand streams
  //========================================
  assign alu_valid = active & alu_en & ~(is_both & alu_sent);
  assign mul_valid = active & mul_en & ~(is_both & mul_sent);
  assign alu_pd    = (!is_both && alu_sent) ? atom_hi : atom_lo;  // hi after lo
  assign mul_pd    = (is_both || mul_sent) ? atom_hi : atom_lo;
  assign alu_xfer  = alu_valid & alu_ready;
  assign mul_xfer  = mul_valid & mul_ready;

  // sent flag means the low half went out in single-use mode
  assign atom_pop  = is_both ? ((alu_sent | alu_xfer) & (mul_sent | mul_xfer))
                             : ((alu_xfer & alu_sent) | (mul_xfer & mul_sent));
  assign lat_ready = atom_pop;
  assign cq_ready  = ~ctx_vld;
  assign last_atom = (atom_cnt == ctx_size);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      alu_sent <= 1'b0;
      mul_sent <= 1'b0;
    end else if (atom_pop) begin
      alu_sent <= 1'b0;
      mul_sent <= 1'b0;
    end else begin
      alu_sent <= alu_sent | alu_xfer;
      mul_sent <= mul_sent | mul_xfer;
    end
  end

  //========================================
  // context and layer tracking
  //========================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ctx_vld     <= 1'b0;
      ctx_size    <= '0;
      atom_cnt    <= '0;
      entry_total <= '0;
      entry_cnt   <= '0;
      eg_done     <= 1'b0;
    end else begin
      eg_done <= atom_pop & last_atom & (entry_cnt + 1'b1 == entry_total);
      if (op_load) begin
        entry_cnt   <= '0;
        entry_total <= (27'(cfg.channel) + 27'd1) * (27'(cfg.height) + 27'd1);
      end else if (atom_pop && last_atom) begin
        entry_cnt <= entry_cnt + 1'b1;
      end
      if (cq_valid && cq_ready) begin
        ctx_vld  <= 1'b1;
        ctx_size <= cq_pd;
        atom_cnt <= '0;
      end else if (atom_pop) begin
        if (last_atom) begin
          ctx_vld <= 1'b0;  // entry complete
        end else begin
          atom_cnt <= atom_cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* verilog/sdp_brdma.sv */
/* bias read DMA top level
   layer switch, request generator, context queue, latency FIFO, egress */

module sdp_brdma #(
  parameter int CQ_DEPTH  = 4,
  parameter int LAT_DEPTH = 8
) (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  input  logic                          reg2dp_op_en,
  input  sdp_brdma_cfg_pkg::brdma_cfg_t reg2dp_cfg,
  output logic                          dp2reg_done,
  output logic [31:0]                   dp2reg_brdma_stall,
  output logic                          dma_rd_req_valid,
  input  logic                          dma_rd_req_ready,
  output sdp_dma_pkg::dma_rd_req_t      dma_rd_req_pd,
  input  logic                          dma_rd_rsp_valid,
  output logic                          dma_rd_rsp_ready,
  input  sdp_dma_pkg::dma_rd_rsp_t      dma_rd_rsp_pd,
  output logic                          dma_rd_cdt_lat_fifo_pop,
  output logic                          alu_valid,
  input  logic                          alu_ready,
  output sdp_dma_pkg::half_t            alu_pd,
  output logic                          mul_valid,
  input  logic                          mul_ready,
  output sdp_dma_pkg::half_t            mul_pd
);

  logic                     op_load;
  logic                     layer_process;
  logic                     eg_done;
  logic                     ig2cq_valid;
  logic                     ig2cq_ready;
  sdp_dma_pkg::cq_entry_t   ig2cq_pd;
  logic                     cq2eg_valid;
  logic                     cq2eg_ready;
  sdp_dma_pkg::cq_entry_t   cq2eg_pd;
  logic                     lat_rd_valid;
  logic                     lat_rd_ready;
  sdp_dma_pkg::dma_rd_rsp_t lat_rd_pd;

  //========================================
  // layer switch
  //========================================
  assign op_load = reg2dp_op_en & ~layer_process;  // one cycle pulse before the flop sets

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_process <= 1'b0;
    end else if (op_load) begin
      layer_process <= 1'b1;
    end else if (eg_done) begin
      layer_process <= 1'b0;
    end
  end

  assign dp2reg_done             = eg_done;
  assign dma_rd_cdt_lat_fifo_pop = lat_rd_valid & lat_rd_ready;  // one credit per atom

  //========================================
  // datapath
  //========================================
  sdp_brdma_ig u_ig (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (reg2dp_cfg),
    .req_valid       (dma_rd_req_valid),
    .req_ready       (dma_rd_req_ready),
    .req_pd          (dma_rd_req_pd),
    .cq_valid        (ig2cq_valid),
    .cq_ready        (ig2cq_ready),
    .cq_pd           (ig2cq_pd),
    .stall_cnt       (dp2reg_brdma_stall)
  );

  sdp_brdma_fifo #(.DEPTH(CQ_DEPTH), .WIDTH(13)) u_cq (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_valid        (ig2cq_valid),
    .wr_ready        (ig2cq_ready),
    .wr_pd           (ig2cq_pd),
    .rd_valid        (cq2eg_valid),
    .rd_ready        (cq2eg_ready),
    .rd_pd           (cq2eg_pd)
  );

  sdp_brdma_fifo #(.DEPTH(LAT_DEPTH), .WIDTH(64)) u_lat_fifo (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .wr_valid        (dma_rd_rsp_valid),
    .wr_ready        (dma_rd_rsp_ready),
    .wr_pd           (dma_rd_rsp_pd),
    .rd_valid        (lat_rd_valid),
    .rd_ready        (lat_rd_ready),
    .rd_pd           (lat_rd_pd)
  );

  sdp_brdma_eg u_eg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cfg             (reg2dp_cfg),
    .cq_valid        (cq2eg_valid),
    .cq_ready        (cq2eg_ready),
    .cq_pd           (cq2eg_pd),
    .lat_valid       (lat_rd_valid),
    .lat_ready       (lat_rd_ready),
    .lat_pd          (lat_rd_pd),
    .alu_valid       (alu_valid),
    .alu_ready       (alu_ready),
    .alu_pd          (alu_pd),
    .mul_valid       (mul_valid),
    .mul_ready       (mul_ready),
    .mul_pd          (mul_pd),
    .eg_done         (eg_done)
  );

endmodule

/* verif/tb_sdp_brdma.sv */
/* testbench for the bias read DMA
   memory model with credits, operand sinks, scoreboard and layer sequencing */

module tb_sdp_brdma;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LAT_DEPTH = 8;
  localparam int N_TESTS   = 6;
  localparam int N_COLS    = 10;  // words per vector line

  logic                          nvdla_core_clk;
  logic                          nvdla_core_rstn;
  logic                          reg2dp_op_en;
  sdp_brdma_cfg_pkg::brdma_cfg_t reg2dp_cfg;
  logic                          dp2reg_done;
  logic [31:0]                   dp2reg_brdma_stall;
  logic                          dma_rd_req_valid;
  logic                          dma_rd_req_ready;
  sdp_dma_pkg::dma_rd_req_t      dma_rd_req_pd;
  logic                          dma_rd_rsp_valid;
  logic                          dma_rd_rsp_ready;
  sdp_dma_pkg::dma_rd_rsp_t      dma_rd_rsp_pd;
  logic                          dma_rd_cdt_lat_fifo_pop;
  logic                          alu_valid;
  logic                          alu_ready;
  sdp_dma_pkg::half_t            alu_pd;
  logic                          mul_valid;
  logic                          mul_ready;
  sdp_dma_pkg::half_t            mul_pd;

  logic [31:0]                   vec [N_TESTS*N_COLS];
  integer                        seed;
  sdp_brdma_cfg_pkg::atom_addr_t exp_req_q [$];
  sdp_dma_pkg::half_t            exp_alu_q [$];
  sdp_dma_pkg::half_t            exp_mul_q [$];
  sdp_brdma_cfg_pkg::atom_addr_t rsp_q [$];     // atoms owed by memory
  int req_cnt;
  int alu_cnt;
  int mul_cnt;
  int rsp_cnt;
  int credit_cnt;
  int stall_seen;
  int done_cnt;
  int in_flight;     // atoms delivered but not yet credited
  int mismatch_cnt;
  int fail_cnt;
  int cycle_cnt;
  int cycle_limit;

  sdp_brdma #(.CQ_DEPTH(4), .LAT_DEPTH(LAT_DEPTH)) u_sdp_brdma (.*);

  initial nvdla_core_clk = 1'b0;
  always #2 nvdla_core_clk = ~nvdla_core_clk;

  // memory content {A + 0x1000, A} per atom
  function automatic sdp_dma_pkg::atom_t atom_data(input sdp_brdma_cfg_pkg::atom_addr_t a);
    return {32'(a) + 32'h1000, 32'(a)};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Mismatch %s: got %h, expected %h", name, got, exp);
    mismatch_cnt++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    fail_cnt++;
  endtask

  //========================================
  // layer setup and expected streams
  //========================================
  task automatic load_layer(input int t);
    int b;
    int s;
    int l;
    int i;
    sdp_brdma_cfg_pkg::atom_addr_t addr;
    sdp_dma_pkg::atom_t d;
    b = t * N_COLS;
    reg2dp_cfg.base_addr      = vec[b][26:0];
    reg2dp_cfg.line_stride    = vec[b+1][26:0];
    reg2dp_cfg.surface_stride = vec[b+2][26:0];
    reg2dp_cfg.width          = vec[b+3][12:0];
    reg2dp_cfg.height         = vec[b+4][12:0];
    reg2dp_cfg.channel        = vec[b+5][12:0];
    reg2dp_cfg.data_use       = sdp_brdma_cfg_pkg::data_use_e'(vec[b+6][1:0]);
    reg2dp_cfg.perf_dma_en    = vec[b+7][0];
    exp_req_q.delete();
    exp_alu_q.delete();
    exp_mul_q.delete();
    for (s = 0; s <= reg2dp_cfg.channel; s++) begin
      for (l = 0; l <= reg2dp_cfg.height; l++) begin  // surface major
        addr = reg2dp_cfg.base_addr + s * reg2dp_cfg.surface_stride + l * reg2dp_cfg.line_stride;
        exp_req_q.push_back(addr);
        for (i = 0; i <= reg2dp_cfg.width; i++) begin
          d = atom_data(addr + i);
          if (reg2dp_cfg.data_use == sdp_brdma_cfg_pkg::use_both) begin
            exp_alu_q.push_back(d[31:0]);
            exp_mul_q.push_back(d[63:32]);
          end else if (reg2dp_cfg.data_use == sdp_brdma_cfg_pkg::use_alu) begin
            exp_alu_q.push_back(d[31:0]);
            exp_alu_q.push_back(d[63:32]);
          end else begin
            exp_mul_q.push_back(d[31:0]);
            exp_mul_q.push_back(d[63:32]);
          end
        end
      end
    end
    req_cnt    = 0;
    alu_cnt    = 0;
    mul_cnt    = 0;
    rsp_cnt    = 0;
    credit_cnt = 0;
    stall_seen = 0;
  endtask

  task automatic check_layer(input int t);
    int b;
    int lines;
    b = t * N_COLS;
    lines = (reg2dp_cfg.channel + 1) * (reg2dp_cfg.height + 1);
    assert (req_cnt == lines) else report_mismatch("request count", req_cnt, lines);
    assert (alu_cnt == vec[b+8]) else report_mismatch("alu_valid beats", alu_cnt, vec[b+8]);
    assert (mul_cnt == vec[b+9]) else report_mismatch("mul_valid beats", mul_cnt, vec[b+9]);
    assert (rsp_cnt == lines * (reg2dp_cfg.width + 1))
      else report_mismatch("response atoms", rsp_cnt, lines * (reg2dp_cfg.width + 1));
    assert (credit_cnt == rsp_cnt)
      else report_mismatch("dma_rd_cdt_lat_fifo_pop count", credit_cnt, rsp_cnt);
    assert (done_cnt == t + 1) else report_mismatch("dp2reg_done count", done_cnt, t + 1);
    assert (dp2reg_brdma_stall == (reg2dp_cfg.perf_dma_en ? stall_seen : 0))
      else report_mismatch("dp2reg_brdma_stall", dp2reg_brdma_stall,
                           reg2dp_cfg.perf_dma_en ? stall_seen : 0);
    assert (exp_alu_q.size() == 0 && exp_mul_q.size() == 0)
      else report_failure("layer finished with operand beats still missing");
  endtask

  //========================================
  // per cycle monitor, memory model, sinks
  //========================================
  always @(posedge nvdla_core_clk) begin : monitor
    int k;
    logic rsp_taken;
    sdp_brdma_cfg_pkg::atom_addr_t a;
    sdp_dma_pkg::half_t h;
    if (nvdla_core_rstn) begin
      cycle_cnt++;
      rsp_taken = dma_rd_rsp_valid & dma_rd_rsp_ready;
      if (dma_rd_req_valid && dma_rd_req_ready) begin
        req_cnt++;
        assert (exp_req_q.size() > 0) else report_failure("request beyond the end of the layer");
        if (exp_req_q.size() > 0) begin
          a = exp_req_q.pop_front();
          assert (dma_rd_req_pd.addr == a) else report_mismatch("dma_rd_req_pd.addr",
                                                               dma_rd_req_pd.addr, a);
        end
        assert (dma_rd_req_pd.size == reg2dp_cfg.width)
          else report_mismatch("dma_rd_req_pd.size", dma_rd_req_pd.size, reg2dp_cfg.width);
        for (k = 0; k <= dma_rd_req_pd.size; k++) begin
          rsp_q.push_back(dma_rd_req_pd.addr + k);
        end
      end
      if (dma_rd_req_valid && !dma_rd_req_ready) stall_seen++;
      if (rsp_taken) begin
        a = rsp_q.pop_front();
        rsp_cnt++;
        in_flight++;
      end
      if (dma_rd_cdt_lat_fifo_pop) begin
        credit_cnt++;
        in_flight--;
      end
      if (alu_valid && alu_ready) begin
        alu_cnt++;
        assert (exp_alu_q.size() > 0) else report_failure("ALU beat with no expected data");
        if (exp_alu_q.size() > 0) begin
          h = exp_alu_q.pop_front();
          assert (alu_pd == h) else report_mismatch("alu_pd", alu_pd, h);
        end
      end
      if (mul_valid && mul_ready) begin
        mul_cnt++;
        assert (exp_mul_q.size() > 0) else report_failure("MUL beat with no expected data");
        if (exp_mul_q.size() > 0) begin
          h = exp_mul_q.pop_front();
          assert (mul_pd == h) else report_mismatch("mul_pd", mul_pd, h);
        end
      end
      if (reg2dp_cfg.data_use == sdp_brdma_cfg_pkg::use_alu) begin
        assert (!mul_valid) else report_failure("MUL stream valid in ALU-only mode");
      end
      if (reg2dp_cfg.data_use == sdp_brdma_cfg_pkg::use_mul) begin
        assert (!alu_valid) else report_failure("ALU stream valid in MUL-only mode");
      end
      if (dp2reg_done) done_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("ERROR: timeout waiting for done");
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt + 1);
        $display("SIMULATION FAILED");
        $finish;
      end
      #0.5;
      dma_rd_req_ready = (($random(seed) & 3) != 0);
      alu_ready        = (($random(seed) & 3) != 0);
      mul_ready        = (($random(seed) & 3) != 0);
      if (!dma_rd_rsp_valid || rsp_taken) begin  // pd only moves after a transfer
        if (rsp_q.size() > 0 && in_flight < LAT_DEPTH && (($random(seed) & 3) != 0)) begin
          dma_rd_rsp_valid   = 1'b1;
          dma_rd_rsp_pd.data = atom_data(rsp_q[0]);
        end else begin
          dma_rd_rsp_valid = 1'b0;
        end
      end
    end
  end

  //========================================
  // layer sequencing
  //========================================
  initial begin
    int t;
    seed             = 32'h5da0;
    nvdla_core_rstn  = 1'b0;
    reg2dp_op_en     = 1'b0;
    reg2dp_cfg       = '0;
    dma_rd_req_ready = 1'b0;
    dma_rd_rsp_valid = 1'b0;
    dma_rd_rsp_pd    = '0;
    alu_ready        = 1'b0;
    mul_ready        = 1'b0;
    mismatch_cnt     = 0;
    fail_cnt         = 0;
    done_cnt         = 0;
    in_flight        = 0;
    cycle_cnt        = 0;
    $readmemh("verif/sdp_brdma_vectors.txt", vec);
    cycle_limit = 0;
    for (t = 0; t < N_TESTS; t++) begin
      cycle_limit += 20 * (vec[t*N_COLS+8] + vec[t*N_COLS+9]) + 200;
    end
    repeat (16) @(posedge nvdla_core_clk);
    #0.5;
    nvdla_core_rstn = 1'b1;
    load_layer(0);
    reg2dp_op_en = 1'b1;  // stays high so layers chain on done
    for (t = 0; t < N_TESTS; t++) begin
      @(posedge nvdla_core_clk);
      while (!dp2reg_done) @(posedge nvdla_core_clk);
      #0.5;
      check_layer(t);
      if (t + 1 < N_TESTS) begin
        load_layer(t + 1);
      end else begin
        reg2dp_op_en = 1'b0;
      end
    end
    repeat (20) @(posedge nvdla_core_clk);
    assert (done_cnt == N_TESTS) else report_mismatch("dp2reg_done count", done_cnt, N_TESTS);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verif/sdp_brdma_vectors.txt */
// columns: base line_stride surface_stride width height channel data_use perf_dma_en alu_beats mul_beats
// hex fields, dims are value minus one, data_use 0 mul / 1 alu / 2 both
0000100 010 080 3 1 1 2 1 10 10
0002000 008 040 1 2 0 1 1 0c 00
0003000 004 100 0 3 2 0 0 00 18
7ff0000 020 200 7 0 3 2 1 20 20
0000000 002 006 1 2 1 1 0 18 00
0040000 040 400 f 3 0 2 0 40 40

/* filelist.f */
verilog/sdp_brdma_cfg_pkg.sv
verilog/sdp_dma_pkg.sv
verilog/sdp_brdma_fifo.sv
verilog/sdp_brdma_ig.sv
verilog/sdp_brdma_eg.sv
verilog/sdp_brdma.sv
verif/tb_sdp_brdma.sv

/* Bender.yml */
package:
  name: sdp_brdma

sources:
  - verilog/sdp_brdma_cfg_pkg.sv
  - verilog/sdp_dma_pkg.sv
  - verilog/sdp_brdma_fifo.sv
  - verilog/sdp_brdma_ig.sv
  - verilog/sdp_brdma_eg.sv
  - verilog/sdp_brdma.sv
  - target: test
    files:
      - verif/tb_sdp_brdma.sv
